/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_resdmac
FILELIST   = build.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench prints its pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+.
resdmac_pkg.sv
scsi_packer.sv
dma_fifo.sv
cpu_sm_outputs.sv
cpu_sm.sv
resdmac_top.sv
tb_resdmac.sv

/* cpu_sm.sv */
// CPU-side bus master writing FIFO longwords to memory on a 68030-style bus
`include "resdmac_defs.svh"

module cpu_sm
    import resdmac_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    input  logic [`RESDMAC_AW-1:0] start_addr,
    input  logic                   fifo_empty,
    input  logic [`RESDMAC_DW-1:0] head_data,
    output logic                   pop,
    input  logic                   bg_n,
    input  logic [1:0]             dsack_n,
    input  logic                   sterm_n,
    output logic                   br_n,
    output logic                   bgack_n,
    output logic                   as_n,
    output logic                   ds_n,
    output logic                   rw,
    output logic [`RESDMAC_AW-1:0] addr,
    output logic [1:0]             siz,
    output logic [`RESDMAC_DW-1:0] data_out
);

    cpu_state_e             state;
    cpu_state_e             next_state;
    logic                   br_d, bgack_d, as_d, ds_d, size1_d;
    logic                   f2cpu_h_d, f2cpu_l_d, pop_d, inc_addr_d;
    logic [`RESDMAC_AW-1:0] addr_q;

    cpu_sm_outputs u_outputs (
        .state      (state),
        .fifo_empty (fifo_empty),
        .bg_n       (bg_n),
        .dsack_n    (dsack_n),
        .sterm_n    (sterm_n),
        .next_state (next_state),
        .br_d       (br_d),
        .bgack_d    (bgack_d),
        .as_d       (as_d),
        .ds_d       (ds_d),
        .size1_d    (size1_d),
        .f2cpu_h_d  (f2cpu_h_d),
        .f2cpu_l_d  (f2cpu_l_d),
        .pop_d      (pop_d),
        .inc_addr_d (inc_addr_d)
    );

    // State and bus strobes, active low on the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CS_IDLE;
            br_n    <= 1'b1;
            bgack_n <= 1'b1;
            as_n    <= 1'b1;
            ds_n    <= 1'b1;
            rw      <= 1'b1;
            siz     <= 2'b00;
            pop     <= 1'b0;
        end else begin
            state   <= next_state;
            br_n    <= ~br_d;
            bgack_n <= ~bgack_d;
            as_n    <= ~as_d;
            ds_n    <= ~ds_d;
            // Write direction for as long as the bus is ours
            rw      <= ~bgack_d;
            siz     <= {size1_d, 1'b0};
            pop     <= pop_d;
        end
    end

    // Longword address counter, advanced as the head leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (go && (state == CS_IDLE)) begin
            addr_q <= start_addr;
        end else if (inc_addr_d) begin
            addr_q <= addr_q + `RESDMAC_AW'(4);
        end
    end

    // Word cycles sit at the second half of the longword
    assign addr = siz[1] ? addr_q + `RESDMAC_AW'(2) : addr_q;

    // Data lanes, held between cycles
    always_ff @(posedge clk) begin
        if (f2cpu_h_d || f2cpu_l_d) begin
            data_out[`RESDMAC_DW-1:`RESDMAC_DW/2] <= f2cpu_h_d ?
                head_data[`RESDMAC_DW-1:`RESDMAC_DW/2] : head_data[`RESDMAC_DW/2-1:0];
            data_out[`RESDMAC_DW/2-1:0] <= (f2cpu_h_d && f2cpu_l_d) ?
                head_data[`RESDMAC_DW/2-1:0] : '0;
        end
    end

    // Address strobe only while we hold bus-grant acknowledge
    a_as_needs_bgack: assert property (
        @(posedge clk) disable iff (!rst_n)
        !as_n |-> !bgack_n
    ) else $error("as_n low without bgack_n");

    // A pop always follows a strobed cycle that the memory terminated
    a_pop_after_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> $past(!as_n) && as_n
    ) else $error("pop without a completed bus cycle");

endmodule

/* cpu_sm_outputs.sv */
// Decoder for the CPU bus master; gives next state and next-cycle strobes, registered in cpu_sm
module cpu_sm_outputs
    import resdmac_pkg::*;
(
    input  cpu_state_e state,
    input  logic       fifo_empty,
    input  logic       bg_n,
    input  logic [1:0] dsack_n,
    input  logic       sterm_n,
    output cpu_state_e next_state,
    output logic       br_d,
    output logic       bgack_d,
    output logic       as_d,
    output logic       ds_d,
    output logic       size1_d,
    output logic       f2cpu_h_d,
    output logic       f2cpu_l_d,
    output logic       pop_d,
    output logic       inc_addr_d
);

    logic s_idle, s_req, s_grant, s_long, s_term, s_hi, s_gap, s_lo;
    logic term32, term16, done_lo, start;

    assign s_idle  = (state == CS_IDLE);
    assign s_req   = (state == CS_REQ);
    assign s_grant = (state == CS_GRANT);
    assign s_long  = (state == CS_LONG);
    assign s_term  = (state == CS_TERM);
    assign s_hi    = (state == CS_HI);
    assign s_gap   = (state == CS_GAP);
    assign s_lo    = (state == CS_LO);

    // Both DSACKs or STERM mean the port took the whole longword
    assign term32  = ~sterm_n | (dsack_n == 2'b00);
    // DSACK1 alone marks a 16-bit port that took only the upper word
    assign term16  = sterm_n & (dsack_n == 2'b01);
    // Word cycle ends on DSACK1 or STERM
    assign done_lo = ~sterm_n | ~dsack_n[1];
    // Bus owned and a word waiting
    assign start   = s_grant & ~fifo_empty;

    always_comb begin
        case (state)
            CS_IDLE:  next_state = fifo_empty ? CS_IDLE : CS_REQ;
            CS_REQ:   next_state = bg_n ? CS_REQ : CS_GRANT;
            CS_GRANT: next_state = fifo_empty ? CS_REL : CS_LONG;
            CS_LONG:  next_state = term32 ? CS_TERM : (term16 ? CS_HI : CS_LONG);
            CS_HI:    next_state = CS_GAP;
            CS_GAP:   next_state = CS_LO;
            CS_LO:    next_state = done_lo ? CS_TERM : CS_LO;
            // Decide in CS_GRANT, once the pop has settled the FIFO level
            CS_TERM:  next_state = CS_GRANT;
            default:  next_state = CS_IDLE;
        endcase
    end

    assign br_d    = (s_idle & ~fifo_empty) | (s_req & bg_n);
    assign bgack_d = (s_req & ~bg_n) | start | s_long | s_hi | s_gap | s_lo | s_term;

    // Strobes low for the long cycle, the extra upper-word clock and the lower word
    assign as_d = start | (s_long & ~term32) | s_gap | (s_lo & ~done_lo);
    assign ds_d = as_d;

    // Word size from the gap onward, long otherwise
    assign size1_d = s_hi | s_gap | (s_lo & ~done_lo);

    // Upper half on the upper lanes
    assign f2cpu_h_d = start | (s_long & ~term32);
    // Lower half goes on the lower lanes for a long cycle and is routed up for a word cycle
    assign f2cpu_l_d = start | (s_long & ~term32 & ~term16) | s_hi | s_gap |
                       (s_lo & ~done_lo);

    assign pop_d      = (s_long & term32) | (s_lo & done_lo);
    assign inc_addr_d = s_term;

endmodule

/* dma_fifo.sv */
// Show-ahead longword FIFO between the SCSI packer and the CPU bus master
`include "resdmac_defs.svh"

module dma_fifo (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  logic [`RESDMAC_DW-1:0]       push_data,
    input  logic                         pop,
    output logic [`RESDMAC_DW-1:0]       head_data,
    output logic                         empty,
    output logic                         full,
    output logic [`RESDMAC_FIFO_LOG2:0]  count
);

    logic [`RESDMAC_DW-1:0]        mem [`RESDMAC_FIFO_DEPTH];
    logic [`RESDMAC_FIFO_LOG2-1:0] wr_ptr;
    logic [`RESDMAC_FIFO_LOG2-1:0] rd_ptr;

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Head is valid whenever empty is low
    assign head_data = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == `RESDMAC_FIFO_DEPTH);

    // Packer honours full through the SCSI side's hold-off
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !full
    ) else $error("FIFO push while full");

    // Bus master only pops a word it has written out
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    ) else $error("FIFO pop while empty");

endmodule

/* resdmac_defs.svh */
// Shared sizes for the SCSI DMA write path, included by RTL and testbench sources
`ifndef RESDMAC_DEFS_SVH
`define RESDMAC_DEFS_SVH

// FIFO depth in longwords, as log2 and as the count itself
`define RESDMAC_FIFO_LOG2 3
`define RESDMAC_FIFO_DEPTH 8

// 68030 bus address width
`define RESDMAC_AW 32

// Bus and FIFO data width, one longword
`define RESDMAC_DW 32

`endif

/* resdmac_pkg.sv */
// Types shared by the DMA write path modules; import it where the state enums are used
package resdmac_pkg;

    // CPU-side bus master states
    typedef enum logic [3:0] {
        CS_IDLE  = 4'd0,
        // Bus requested, waiting for grant
        CS_REQ   = 4'd1,
        // Bus owned, strobes high
        CS_GRANT = 4'd2,
        // Long cycle, strobes low
        CS_LONG  = 4'd3,
        // Strobes high, head popped
        CS_TERM  = 4'd4,
        // 16-bit port took the upper word
        CS_HI    = 4'd5,
        // Strobes high between the two word cycles
        CS_GAP   = 4'd6,
        // Lower word cycle at addr+2
        CS_LO    = 4'd7,
        // Give the bus back
        CS_REL   = 4'd8
    } cpu_state_e;

    // Byte lane that the next SCSI byte lands in, most significant first
    typedef enum logic [1:0] {
        PK_B3 = 2'd0,
        PK_B2 = 2'd1,
        PK_B1 = 2'd2,
        PK_B0 = 2'd3
    } pack_state_e;

endpackage

/* resdmac_top.sv */
// Top of the SCSI DMA write path: packer, longword FIFO and CPU bus master
`include "resdmac_defs.svh"

module resdmac_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // SCSI side
    input  logic                   sbyte_stb,
    input  logic [7:0]             sbyte,
    output logic                   scsi_full,
    // Transfer start
    input  logic                   go,
    input  logic [`RESDMAC_AW-1:0] start_addr,
    // 68030 bus
    input  logic                   bg_n,
    input  logic [1:0]             dsack_n,
    input  logic                   sterm_n,
    output logic                   br_n,
    output logic                   bgack_n,
    output logic                   as_n,
    output logic                   ds_n,
    output logic                   rw,
    output logic [`RESDMAC_AW-1:0] addr,
    output logic [1:0]             siz,
    output logic [`RESDMAC_DW-1:0] data_out
);

    logic                   push;
    logic [`RESDMAC_DW-1:0] push_data;
    logic                   pop;
    logic [`RESDMAC_DW-1:0] head_data;
    logic                   fifo_empty;

    scsi_packer u_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .sbyte_stb (sbyte_stb),
        .sbyte     (sbyte),
        .full      (scsi_full),
        .push      (push),
        .push_data (push_data)
    );

    // Occupancy count is for debug only
    dma_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .empty     (fifo_empty),
        .full      (scsi_full),
        .count     ()
    );

    cpu_sm u_cpu (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .start_addr (start_addr),
        .fifo_empty (fifo_empty),
        .head_data  (head_data),
        .pop        (pop),
        .bg_n       (bg_n),
        .dsack_n    (dsack_n),
        .sterm_n    (sterm_n),
        .br_n       (br_n),
        .bgack_n    (bgack_n),
        .as_n       (as_n),
        .ds_n       (ds_n),
        .rw         (rw),
        .addr       (addr),
        .siz        (siz),
        .data_out   (data_out)
    );

endmodule

/* scsi_packer.sv */
// Packs SCSI byte strobes into longwords and pushes each completed word into the FIFO
`include "resdmac_defs.svh"

module scsi_packer
    import resdmac_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sbyte_stb,
    input  logic [7:0]             sbyte,
    input  logic                   full,
    output logic                   push,
    output logic [`RESDMAC_DW-1:0] push_data
);

    pack_state_e           lane;
    pack_state_e           lane_next;
    logic [`RESDMAC_DW-1:0] hold;

    // Lane pointer wraps after the least significant byte
    always_comb begin
        case (lane)
            PK_B3:   lane_next = PK_B2;
            PK_B2:   lane_next = PK_B1;
            PK_B1:   lane_next = PK_B0;
            default: lane_next = PK_B3;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane <= PK_B3;
            push <= 1'b0;
        end else begin
            // Fourth byte completes the word, push follows one clock later
            push <= sbyte_stb && (lane == PK_B0);
            if (sbyte_stb) begin
                lane <= lane_next;
            end
        end
    end

    // Holding register, one byte lane per strobe
    always_ff @(posedge clk) begin
        if (sbyte_stb) begin
            case (lane)
                PK_B3:   hold[31:24] <= sbyte;
                PK_B2:   hold[23:16] <= sbyte;
                PK_B1:   hold[15:8]  <= sbyte;
                default: hold[7:0]   <= sbyte;
            endcase
        end
    end

    // The FIFO samples the word at the edge that ends the push cycle,
    // before any byte of the next word can reach the top lane
    assign push_data = hold;

    // SCSI side must hold off while the FIFO reports full
    a_no_strobe_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        sbyte_stb |-> !full
    ) else $error("byte strobe while FIFO full");

endmodule

/* tb_resdmac.sv */
// Testbench for the SCSI DMA write path; run through build.f with the Makefile
`include "resdmac_defs.svh"

module tb_resdmac
    import resdmac_pkg::*;
;

    localparam int MODE_LONG   = 0;
    localparam int MODE_STERM  = 1;
    localparam int MODE_WORD   = 2;
    localparam int TOTAL_BYTES = 32 * 3 + 16 + 40;

    logic                   clk;
    logic                   rst_n;
    logic                   sbyte_stb;
    logic [7:0]             sbyte;
    logic                   scsi_full;
    logic                   go;
    logic [`RESDMAC_AW-1:0] start_addr;
    logic                   bg_n;
    logic [1:0]             dsack_n;
    logic                   sterm_n;
    logic                   br_n;
    logic                   bgack_n;
    logic                   as_n;
    logic                   ds_n;
    logic                   rw;
    logic [`RESDMAC_AW-1:0] addr;
    logic [1:0]             siz;
    logic [`RESDMAC_DW-1:0] data_out;

    // Test context shared by the stimulus, bus models and checker
    string                  cur_test;
    int                     mode;
    int                     grant_delay;
    bit                     grant_hold;
    logic [`RESDMAC_AW-1:0] cur_base;
    logic [7:0]             stream [$];
    int                     wr_count;
    int                     errors;
    int                     test_errors;
    int                     tests;
    int                     failed;

    // Writes seen by the memory model, waiting for the checker
    logic [`RESDMAC_AW-1:0] rec_addr [$];
    logic [`RESDMAC_DW-1:0] rec_data [$];
    logic [1:0]             rec_siz [$];
    logic                   rec_rw [$];

    resdmac_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .sbyte_stb  (sbyte_stb),
        .sbyte      (sbyte),
        .scsi_full  (scsi_full),
        .go         (go),
        .start_addr (start_addr),
        .bg_n       (bg_n),
        .dsack_n    (dsack_n),
        .sterm_n    (sterm_n),
        .br_n       (br_n),
        .bgack_n    (bgack_n),
        .as_n       (as_n),
        .ds_n       (ds_n),
        .rw         (rw),
        .addr       (addr),
        .siz        (siz),
        .data_out   (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Longword at the given index with the first byte of the group most significant
    function automatic logic [`RESDMAC_DW-1:0] expected_long(input logic [7:0] bytes [$],
                                                             input int index);
        logic [`RESDMAC_DW-1:0] word;
        word = 'x;
        if (4 * index + 3 < bytes.size()) begin
            word = {bytes[4*index], bytes[4*index+1], bytes[4*index+2], bytes[4*index+3]};
        end
        return word;
    endfunction

    task automatic check_long(input string what, input logic [`RESDMAC_AW-1:0] exp_addr,
                              input logic [`RESDMAC_DW-1:0] exp_data,
                              input logic [`RESDMAC_AW-1:0] got_addr,
                              input logic [`RESDMAC_DW-1:0] got_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            errors++;
            test_errors++;
            $display("ERR %s %s: expected %h @ %h, actual %h @ %h", cur_test, what,
                     exp_data, exp_addr, got_data, got_addr);
        end
    endtask

    task automatic check_state(input string what, input cpu_state_e exp_state,
                               input cpu_state_e got_state);
        if (got_state !== exp_state) begin
            errors++;
            test_errors++;
            $display("ERR %s %s: expected %s, actual %s", cur_test, what,
                     exp_state.name(), got_state.name());
        end
    endtask

    task automatic check_flag(input string what, input logic exp_level, input logic got_level);
        if (got_level !== exp_level) begin
            errors++;
            test_errors++;
            $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp_level, got_level);
        end
    endtask

    task automatic begin_test(input string name, input int m, input int nbytes);
        cur_test    = name;
        test_errors = 0;
        mode        = m;
        wr_count    = 0;
        stream.delete();
        for (int i = 0; i < nbytes; i++) begin
            stream.push_back(8'($urandom));
        end
    endtask

    task automatic end_test();
        tests++;
        if (test_errors == 0) begin
            $display("test %s: pass", cur_test);
        end else begin
            failed++;
            $display("test %s: %0d mismatches", cur_test, test_errors);
        end
    endtask

    // One go pulse while the bus master sits idle
    task automatic start_transfer(input logic [`RESDMAC_AW-1:0] base);
        cur_base   = base;
        go         = 1'b1;
        start_addr = base;
        @(posedge clk);
        #10;
        go = 1'b0;
    endtask

    task automatic send_bytes(input int first, input int last, input bit check_room);
        for (int i = first; i < last; i++) begin
            if (check_room) begin
                check_flag($sformatf("scsi_full before byte %0d", i), 1'b0, scsi_full);
            end else begin
                while (scsi_full) begin
                    @(posedge clk);
                    #10;
                end
            end
            sbyte_stb = 1'b1;
            sbyte     = stream[i];
            @(posedge clk);
            #10;
            sbyte_stb = 1'b0;
            repeat ($urandom_range(0, 2)) begin
                @(posedge clk);
                #10;
            end
        end
    endtask

    // Done when every write is checked and the master has given the bus back
    task automatic wait_idle(input int n_writes);
        int cycles;
        cycles = 0;
        while (!(wr_count == n_writes && bgack_n)) begin
            @(posedge clk);
            #10;
            cycles++;
            if (cycles > 2000) begin
                errors++;
                test_errors++;
                $display("%s: transfer did not finish, %0d of %0d writes seen",
                         cur_test, wr_count, n_writes);
                return;
            end
        end
        // Release passes through CS_REL and lands in idle one clock later
        @(posedge clk);
        #10;
        check_flag("bgack_n after drain", 1'b1, bgack_n);
        check_flag("br_n after drain", 1'b1, br_n);
        check_flag("as_n after drain", 1'b1, as_n);
        check_state("final state", CS_IDLE, dut0.u_cpu.state);
    endtask

    task automatic run_stream(input string name, input int m, input int nbytes,
                              input logic [`RESDMAC_AW-1:0] base, input int gdelay);
        begin_test(name, m, nbytes);
        grant_delay = gdelay;
        start_transfer(base);
        send_bytes(0, nbytes, 1'b0);
        wait_idle((m == MODE_WORD) ? nbytes / 2 : nbytes / 4);
        end_test();
    endtask

    initial begin
        void'($urandom(32'he1b3));
        errors      = 0;
        tests       = 0;
        failed      = 0;
        mode        = MODE_LONG;
        grant_delay = 1;
        grant_hold  = 1'b0;
        cur_base    = '0;
        cur_test    = "reset_state";
        rst_n       = 1'b0;
        sbyte_stb   = 1'b0;
        sbyte       = 8'h00;
        go          = 1'b0;
        start_addr  = '0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        begin_test("reset_state", MODE_LONG, 0);
        check_flag("br_n", 1'b1, br_n);
        check_flag("bgack_n", 1'b1, bgack_n);
        check_flag("as_n", 1'b1, as_n);
        check_flag("ds_n", 1'b1, ds_n);
        check_flag("rw", 1'b1, rw);
        check_flag("scsi_full", 1'b0, scsi_full);
        end_test();

        run_stream("long_async", MODE_LONG, 32, 32'h0010_0000, 1);
        run_stream("long_sterm", MODE_STERM, 32, 32'h0020_0400, 2);
        run_stream("word16", MODE_WORD, 32, 32'h0030_1000, 0);
        run_stream("arbitration", MODE_LONG, 16, 32'h0040_0000, 6);

        // Bus withheld until the FIFO has filled
        begin_test("backpressure", MODE_LONG, 40);
        grant_hold = 1'b1;
        start_transfer(32'h0050_0000);
        send_bytes(0, 4 * `RESDMAC_FIFO_DEPTH, 1'b1);
        repeat (3) @(posedge clk);
        #10;
        check_flag("scsi_full at depth", 1'b1, scsi_full);
        grant_hold = 1'b0;
        send_bytes(4 * `RESDMAC_FIFO_DEPTH, 40, 1'b0);
        wait_idle(10);
        end_test();

        $display("%0d tests, %0d failed, %0d mismatches", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Arbiter grants after a delay and takes the grant back once bgack_n is low
    initial begin : grant_model
        int wait_left;
        bg_n      = 1'b1;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #10;
            if (!bg_n && !bgack_n) begin
                bg_n = 1'b1;
            end else if (bg_n && !br_n && !grant_hold) begin
                if (wait_left >= grant_delay) begin
                    bg_n      = 1'b0;
                    wait_left = 0;
                end else begin
                    wait_left++;
                end
            end
        end
    end

    // Memory answers after random wait states with the termination of the test's port mode
    initial begin : memory_model
        int wait_left;
        bit busy;
        dsack_n   = 2'b11;
        sterm_n   = 1'b1;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #10;
            if (as_n) begin
                dsack_n   = 2'b11;
                sterm_n   = 1'b1;
                busy      = 1'b0;
                wait_left = $urandom_range(0, 3);
            end else if (!busy) begin
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    busy = 1'b1;
                    rec_addr.push_back(addr);
                    rec_siz.push_back(siz);
                    rec_rw.push_back(rw);
                    // A 16-bit port only sees the upper lanes
                    if (mode == MODE_WORD) begin
                        rec_data.push_back({data_out[31:16], 16'h0000});
                        dsack_n = 2'b01;
                    end else if (mode == MODE_STERM) begin
                        rec_data.push_back(data_out);
                        sterm_n = 1'b0;
                    end else begin
                        rec_data.push_back(data_out);
                        dsack_n = 2'b00;
                    end
                end
            end
        end
    end

    initial begin : write_checker
        logic [`RESDMAC_AW-1:0] got_addr;
        logic [`RESDMAC_DW-1:0] got_data;
        logic [`RESDMAC_DW-1:0] lw;
        logic [`RESDMAC_DW-1:0] exp_data;
        logic [1:0]             got_siz;
        logic                   got_rw;
        int                     idx;
        int                     half;
        forever begin
            @(posedge clk);
            #20;
            while (rec_addr.size() > 0) begin
                got_addr = rec_addr.pop_front();
                got_data = rec_data.pop_front();
                got_siz  = rec_siz.pop_front();
                got_rw   = rec_rw.pop_front();
                idx      = (mode == MODE_WORD) ? wr_count / 2 : wr_count;
                half     = (mode == MODE_WORD) ? wr_count % 2 : 0;
                lw       = expected_long(stream, idx);
                // Upper word first at the longword address and the lower word at +2
                if (mode == MODE_WORD) begin
                    exp_data = half ? {lw[15:0], 16'h0000} : {lw[31:16], 16'h0000};
                end else begin
                    exp_data = lw;
                end
                check_long($sformatf("write %0d", wr_count),
                           cur_base + `RESDMAC_AW'(4 * idx + 2 * half), exp_data,
                           got_addr, got_data);
                check_flag("siz word", (mode == MODE_WORD && half == 1), got_siz[1]);
                check_flag("siz bit 0", 1'b0, got_siz[0]);
                check_flag("rw during write", 1'b0, got_rw);
                wr_count++;
            end
        end
    end

    // Bus ownership rules checked every cycle
    initial begin : arbitration_monitor
        forever begin
            @(posedge clk);
            #10;
            if (rst_n && !as_n) begin
                check_flag("bgack_n under as_n", 1'b0, bgack_n);
            end
            if (rst_n && !bgack_n) begin
                check_flag("br_n while bgack_n low", 1'b1, br_n);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = TOTAL_BYTES * 40 + 2000;
        repeat (limit) @(posedge clk);
        $display("timeout: run still going after %0d clock cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
